//--- verilog/attitude_consts.svh
`ifndef ATTITUDE_CONSTS_SVH
`define ATTITUDE_CONSTS_SVH

`default_nettype none

// widths
`define REC_W         8
`define RATE_W        16
`define CFG_ADDR_W    3

// configuration register map, scales then limits
`define CFG_SCALE_THR   3'd0
`define CFG_SCALE_YAW   3'd1
`define CFG_SCALE_PITCH 3'd2
`define CFG_SCALE_ROLL  3'd3
`define CFG_LIM_THR     3'd4
`define CFG_LIM_YAW     3'd5
`define CFG_LIM_PITCH   3'd6
`define CFG_LIM_ROLL    3'd7

// stick mapping
`define MAP_OFFSET    16'sd500
`define YAW_CENTER    9'sd125
`define THROTTLE_IDLE 8'd10

// angles in Q12.4 degrees
`define ANGLE_90      16'sd1440
`define ANGLE_270     16'sd4320
`define ANGLE_360     16'sd5760
// heading is tracked at four times the angle resolution
`define HEADING_WRAP  23040

// reset values of the configuration
`define DEF_SCALE_MULT   16'sd1
`define DEF_SCALE_SHIFT  5'd0
`define DEF_THROTTLE_MAX 16'sd4000
`define DEF_RATE_LIMIT   16'sd1600

`default_nettype wire

`endif

//--- verilog/attitude_pkg.sv
`include "attitude_consts.svh"
`default_nettype none

package attitude_pkg;

	// raw receiver values, unsigned
	typedef struct packed {
		logic [`REC_W-1:0] throttle;
		logic [`REC_W-1:0] yaw;
		logic [`REC_W-1:0] pitch;
		logic [`REC_W-1:0] roll;
	} rx_targets_t;

	// imu angles, Q12.4 degrees
	typedef struct packed {
		logic signed [`RATE_W-1:0] yaw;
		logic signed [`RATE_W-1:0] pitch;
		logic signed [`RATE_W-1:0] roll;
	} imu_angles_t;

	typedef struct packed {
		logic signed [`RATE_W-1:0] throttle;
		logic signed [`RATE_W-1:0] yaw;
		logic signed [`RATE_W-1:0] pitch;
		logic signed [`RATE_W-1:0] roll;
	} axis_rates_t;

	typedef struct packed {
		logic signed [`RATE_W-1:0] yaw;
		logic signed [`RATE_W-1:0] pitch;
		logic signed [`RATE_W-1:0] roll;
	} angle_errors_t;

	// result = (value * mult) >>> shift
	typedef struct packed {
		logic signed [`RATE_W-1:0] mult;
		logic [4:0]                shift;
	} scale_t;

	typedef struct packed {
		scale_t                    throttle_scale;
		scale_t                    yaw_scale;
		scale_t                    pitch_scale;
		scale_t                    roll_scale;
		logic signed [`RATE_W-1:0] throttle_max;
		logic signed [`RATE_W-1:0] yaw_limit;
		logic signed [`RATE_W-1:0] pitch_limit;
		logic signed [`RATE_W-1:0] roll_limit;
	} ctrl_cfg_t;

	// limit entry, value sits above the shift field position
	typedef struct packed {
		logic signed [`RATE_W-1:0] value;
		logic [4:0]                zero;
	} lim_word_t;

	// one write word, meaning picked by the register address
	typedef union packed {
		scale_t    scale;
		lim_word_t limit;
	} cfg_word_u;

endpackage

`default_nettype wire

//--- verilog/attitude_cfg_regs.sv
`timescale 1ns/1ns
`include "attitude_consts.svh"
`default_nettype none

module attitude_cfg_regs (
	input  wire                        us_clk,
	input  wire                        resetn,
	input  wire                        cfg_wr,
	input  wire [`CFG_ADDR_W-1:0]      cfg_addr,
	input  wire attitude_pkg::cfg_word_u cfg_data,
	output attitude_pkg::ctrl_cfg_t    cfg
);

	localparam attitude_pkg::scale_t SCALE_DEF = '{
		mult:  `DEF_SCALE_MULT,
		shift: `DEF_SCALE_SHIFT
	};

	localparam attitude_pkg::ctrl_cfg_t CFG_DEF = '{
		throttle_scale: SCALE_DEF,
		yaw_scale:      SCALE_DEF,
		pitch_scale:    SCALE_DEF,
		roll_scale:     SCALE_DEF,
		throttle_max:   `DEF_THROTTLE_MAX,
		yaw_limit:      `DEF_RATE_LIMIT,
		pitch_limit:    `DEF_RATE_LIMIT,
		roll_limit:     `DEF_RATE_LIMIT
	};

	// a negative limit would invert the clamp window
	function automatic logic signed [`RATE_W-1:0] non_neg(
		input logic signed [`RATE_W-1:0] val
	);
		if (val < 0)
			return '0;
		return val;
	endfunction

	logic signed [`RATE_W-1:0] lim_val;

	// limit view of the write word, low zero field ignored
	assign lim_val = non_neg(cfg_data.limit.value);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			cfg <= CFG_DEF;
		end else if (cfg_wr) begin
			case (cfg_addr)
				`CFG_SCALE_THR: begin
					cfg.throttle_scale <= cfg_data.scale;
				end
				`CFG_SCALE_YAW: begin
					cfg.yaw_scale <= cfg_data.scale;
				end
				`CFG_SCALE_PITCH: begin
					cfg.pitch_scale <= cfg_data.scale;
				end
				`CFG_SCALE_ROLL: begin
					cfg.roll_scale <= cfg_data.scale;
				end
				`CFG_LIM_THR: begin
					cfg.throttle_max <= lim_val;
				end
				`CFG_LIM_YAW: begin
					cfg.yaw_limit <= lim_val;
				end
				`CFG_LIM_PITCH: begin
					cfg.pitch_limit <= lim_val;
				end
				`CFG_LIM_ROLL: begin
					cfg.roll_limit <= lim_val;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/angle_controller.sv
`timescale 1ns/1ns
`include "attitude_consts.svh"
`default_nettype none

module angle_controller (
	input  wire                          us_clk,
	input  wire                          resetn,
	input  wire                          start,
	input  wire attitude_pkg::rx_targets_t targets,
	input  wire attitude_pkg::imu_angles_t angles,
	input  wire attitude_pkg::ctrl_cfg_t   cfg,
	output attitude_pkg::axis_rates_t    rates,
	output attitude_pkg::angle_errors_t  errors,
	output logic                         active,
	output logic                         done
);

	// one-hot state bit positions
	localparam int S_IDLE     = 0;
	localparam int S_MAP      = 1;
	localparam int S_SCALE    = 2;
	localparam int S_LIMIT    = 3;
	localparam int S_COMPLETE = 4;

	// heading register holds four times a Q12.4 angle
	localparam int HEAD_W = 18;
	localparam logic signed [HEAD_W:0] WRAP = (HEAD_W + 1)'(`HEADING_WRAP);

	logic [4:0] state;
	logic [4:0] state_nxt;
	logic       accept;

	attitude_pkg::rx_targets_t lat_tgt;
	attitude_pkg::imu_angles_t lat_ang;

	logic signed [HEAD_W-1:0] heading;
	logic signed [HEAD_W-1:0] heading_nxt;
	logic signed [HEAD_W:0]   head_sum;
	logic signed [8:0]        yaw_step;
	logic signed [`RATE_W-1:0] yaw_goal;
	logic signed [`RATE_W-1:0] yaw_err;

	attitude_pkg::axis_rates_t map_nxt;
	attitude_pkg::axis_rates_t mapped;
	attitude_pkg::axis_rates_t scaled;

	// multiply, shift, then saturate to 16 bits
	function automatic logic signed [`RATE_W-1:0] scale_sat(
		input logic signed [`RATE_W-1:0] val,
		input attitude_pkg::scale_t      k
	);
		logic signed [31:0] prod;
		prod = (32'(val) * 32'(k.mult)) >>> k.shift;
		if (prod > 32'sd32767)
			return 16'sh7fff;
		else if (prod < -32'sd32768)
			return 16'sh8000;
		return prod[`RATE_W-1:0];
	endfunction

	function automatic logic signed [`RATE_W-1:0] clamp(
		input logic signed [`RATE_W-1:0] val,
		input logic signed [`RATE_W-1:0] lo,
		input logic signed [`RATE_W-1:0] hi
	);
		if (val > hi)
			return hi;
		else if (val < lo)
			return lo;
		return val;
	endfunction

	// a run may start right on the done cycle
	assign accept = start & (state[S_IDLE] | state[S_COMPLETE]);

	always_comb begin
		state_nxt = '0;
		case (1'b1)
			state[S_IDLE]: begin
				if (accept)
					state_nxt[S_MAP] = 1'b1;
				else
					state_nxt[S_IDLE] = 1'b1;
			end
			state[S_MAP]: begin
				state_nxt[S_SCALE] = 1'b1;
			end
			state[S_SCALE]: begin
				state_nxt[S_LIMIT] = 1'b1;
			end
			state[S_LIMIT]: begin
				state_nxt[S_COMPLETE] = 1'b1;
			end
			state[S_COMPLETE]: begin
				if (accept)
					state_nxt[S_MAP] = 1'b1;
				else
					state_nxt[S_IDLE] = 1'b1;
			end
			default: begin
				state_nxt[S_IDLE] = 1'b1;
			end
		endcase
	end

	// heading tracking and mapping
	always_comb begin
		yaw_step = $signed({1'b0, lat_tgt.yaw}) - `YAW_CENTER;
		head_sum = (HEAD_W + 1)'(heading) + (HEAD_W + 1)'(yaw_step);

		// throttle near idle: snap heading to the imu yaw
		if (lat_tgt.throttle < `THROTTLE_IDLE)
			heading_nxt = $signed({lat_ang.yaw, 2'b00});
		else if (head_sum >= WRAP)
			heading_nxt = HEAD_W'(head_sum - WRAP);
		else if (head_sum < 0)
			heading_nxt = HEAD_W'(head_sum + WRAP);
		else
			heading_nxt = HEAD_W'(head_sum);

		yaw_goal = heading_nxt[HEAD_W-1:2];

		// short way around the 0/360 seam
		if (yaw_goal > `ANGLE_270 && lat_ang.yaw < `ANGLE_90)
			yaw_err = yaw_goal - lat_ang.yaw - `ANGLE_360;
		else if (lat_ang.yaw > `ANGLE_270 && yaw_goal < `ANGLE_90)
			yaw_err = yaw_goal - lat_ang.yaw + `ANGLE_360;
		else
			yaw_err = yaw_goal - lat_ang.yaw;

		map_nxt.throttle = $signed({4'b0000, lat_tgt.throttle, 4'b0000});
		map_nxt.yaw      = yaw_err;
		map_nxt.pitch    = $signed({6'b000000, lat_tgt.pitch, 2'b00})
			- `MAP_OFFSET - lat_ang.pitch;
		// imu reports roll inverted, so add it
		map_nxt.roll     = $signed({6'b000000, lat_tgt.roll, 2'b00})
			- `MAP_OFFSET + lat_ang.roll;
	end

	always_ff @(posedge us_clk) begin
		if (accept) begin
			lat_tgt <= targets;
			lat_ang <= angles;
		end
		if (state[S_MAP])
			mapped <= map_nxt;
		if (state[S_SCALE]) begin
			scaled.throttle <= scale_sat(mapped.throttle, cfg.throttle_scale);
			scaled.yaw      <= scale_sat(mapped.yaw, cfg.yaw_scale);
			scaled.pitch    <= scale_sat(mapped.pitch, cfg.pitch_scale);
			scaled.roll     <= scale_sat(mapped.roll, cfg.roll_scale);
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state   <= 5'b00001;
			heading <= '0;
			active  <= 1'b0;
			done    <= 1'b0;
			rates   <= '0;
			errors  <= '0;
		end else begin
			state  <= state_nxt;
			// busy while scale and limit results are in flight
			active <= state[S_MAP] | state[S_SCALE];
			done   <= state[S_COMPLETE];
			if (state[S_MAP])
				heading <= heading_nxt;
			if (state[S_LIMIT]) begin
				rates.throttle <= clamp(scaled.throttle, '0, cfg.throttle_max);
				rates.yaw      <= clamp(scaled.yaw, -cfg.yaw_limit, cfg.yaw_limit);
				rates.pitch    <= clamp(scaled.pitch, -cfg.pitch_limit, cfg.pitch_limit);
				rates.roll     <= clamp(scaled.roll, -cfg.roll_limit, cfg.roll_limit);
				errors.yaw     <= mapped.yaw;
				errors.pitch   <= mapped.pitch;
				errors.roll    <= mapped.roll;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/attitude_top.sv
`timescale 1ns/1ns
`include "attitude_consts.svh"
`default_nettype none

module attitude_top (
	input  wire                          us_clk,
	input  wire                          resetn,
	input  wire                          cfg_wr,
	input  wire [`CFG_ADDR_W-1:0]        cfg_addr,
	input  wire attitude_pkg::cfg_word_u   cfg_data,
	input  wire                          start,
	input  wire attitude_pkg::rx_targets_t targets,
	input  wire attitude_pkg::imu_angles_t angles,
	output attitude_pkg::axis_rates_t    rates,
	output attitude_pkg::angle_errors_t  errors,
	output logic                         active,
	output logic                         done
);

	// scales and limits seen by the controller
	attitude_pkg::ctrl_cfg_t cfg;

	attitude_cfg_regs u_cfg_regs (
		.us_clk   (us_clk),
		.resetn   (resetn),
		.cfg_wr   (cfg_wr),
		.cfg_addr (cfg_addr),
		.cfg_data (cfg_data),
		.cfg      (cfg)
	);

	angle_controller u_angle_ctrl (
		.us_clk  (us_clk),
		.resetn  (resetn),
		.start   (start),
		.targets (targets),
		.angles  (angles),
		.cfg     (cfg),
		.rates   (rates),
		.errors  (errors),
		.active  (active),
		.done    (done)
	);

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 2
) (
	output logic us_clk,
	output logic resetn
);

	initial begin
		us_clk = 1'b0;
		forever #(PERIOD / 2) us_clk = ~us_clk;
	end

	// power-on reset, released on a rising edge
	initial begin
		resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge us_clk);
		resetn <= 1'b1;
	end

endmodule

`default_nettype wire

//--- testbench/attitude_chk.sv
`timescale 1ns/1ns
`default_nettype none

module attitude_chk (
	input wire us_clk,
	input wire resetn,
	input wire accept,
	input wire active,
	input wire done
);

	// done is a one-cycle strobe
	done_single: assert property (@(posedge us_clk) disable iff (!resetn)
		done |=> !done)
		else $error("done stayed high for two cycles");

	// done rises 4 edges after the accepting edge, seen one sample later
	done_latency: assert property (@(posedge us_clk) disable iff (!resetn)
		accept |-> ##5 done)
		else $error("done did not follow an accepted start after 4 cycles");

	no_overlap: assert property (@(posedge us_clk) disable iff (!resetn)
		!(active && done))
		else $error("active and done were high together");

endmodule

`default_nettype wire

//--- testbench/tb_attitude.sv
`timescale 1ns/1ns
`include "attitude_consts.svh"
`default_nettype none

module tb_attitude;

	localparam int IDLE_THR = int'(`THROTTLE_IDLE);
	localparam int CENTER   = int'(`YAW_CENTER);
	localparam int OFFSET   = int'(`MAP_OFFSET);
	localparam int A90      = int'(`ANGLE_90);
	localparam int A270     = int'(`ANGLE_270);
	localparam int A360     = int'(`ANGLE_360);
	localparam int WRAP     = `HEADING_WRAP;

	logic                        us_clk;
	logic                        por_n;
	logic                        rst_n_tb;
	logic                        resetn;
	logic                        cfg_wr;
	logic [`CFG_ADDR_W-1:0]      cfg_addr;
	attitude_pkg::cfg_word_u     cfg_data;
	logic                        start;
	attitude_pkg::rx_targets_t   targets;
	attitude_pkg::imu_angles_t   angles;
	attitude_pkg::axis_rates_t   rates;
	attitude_pkg::angle_errors_t errors;
	logic                        active;
	logic                        done;

	int     err_count;
	int     timeout_count;
	integer seed;

	// model state, axis order throttle, yaw, pitch, roll
	int m_heading;
	int m_mult[4];
	int m_shift[4];
	int m_lim[4];
	int exp_rate[4];
	int exp_err[3];

	assign resetn = por_n & rst_n_tb;

	tb_clock #(.PERIOD(40), .RESET_CYCLES(2)) u_clock (.us_clk(us_clk), .resetn(por_n));

	attitude_top UUT (
		.us_clk   (us_clk),
		.resetn   (resetn),
		.cfg_wr   (cfg_wr),
		.cfg_addr (cfg_addr),
		.cfg_data (cfg_data),
		.start    (start),
		.targets  (targets),
		.angles   (angles),
		.rates    (rates),
		.errors   (errors),
		.active   (active),
		.done     (done)
	);

	bind angle_controller attitude_chk u_chk (
		.us_clk (us_clk),
		.resetn (resetn),
		.accept (accept),
		.active (active),
		.done   (done)
	);

	function automatic int wrap16(input int v);
		logic signed [15:0] t;
		t = v[15:0];
		return int'(t);
	endfunction

	function automatic int limit_range(input int v, input int lo, input int hi);
		if (v > hi)
			return hi;
		if (v < lo)
			return lo;
		return v;
	endfunction

	task automatic check(input string what, input int got, input int exp);
		if (got !== exp) begin
			err_count++;
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic reset_model();
		m_heading = 0;
		for (int i = 0; i < 4; i++) begin
			m_mult[i]  = 1;
			m_shift[i] = 0;
			m_lim[i]   = 1600;
		end
		m_lim[0] = 4000;
	endtask

	task automatic predict(input attitude_pkg::rx_targets_t t, input attitude_pkg::imu_angles_t a);
		int ay;
		int goal;
		int m[4];
		int s;
		ay = int'($signed(a.yaw));
		if (int'(t.throttle) < IDLE_THR) begin
			m_heading = ay * 4;
		end else begin
			m_heading = m_heading + int'(t.yaw) - CENTER;
			if (m_heading >= WRAP)
				m_heading = m_heading - WRAP;
			else if (m_heading < 0)
				m_heading = m_heading + WRAP;
		end
		goal = m_heading >>> 2;
		// shortest path across 0/360
		if (goal > A270 && ay < A90)
			m[1] = goal - ay - A360;
		else if (ay > A270 && goal < A90)
			m[1] = goal - ay + A360;
		else
			m[1] = goal - ay;
		m[0] = int'(t.throttle) * 16;
		m[2] = int'(t.pitch) * 4 - OFFSET - int'($signed(a.pitch));
		m[3] = int'(t.roll) * 4 - OFFSET + int'($signed(a.roll));
		for (int i = 0; i < 4; i++) begin
			m[i] = wrap16(m[i]);
			s = limit_range((m[i] * m_mult[i]) >>> m_shift[i], -32768, 32767);
			if (i == 0)
				exp_rate[i] = limit_range(s, 0, m_lim[i]);
			else
				exp_rate[i] = limit_range(s, -m_lim[i], m_lim[i]);
		end
		exp_err[0] = m[1];
		exp_err[1] = m[2];
		exp_err[2] = m[3];
	endtask

	task automatic check_outputs();
		check("throttle rate", int'($signed(rates.throttle)), exp_rate[0]);
		check("yaw rate", int'($signed(rates.yaw)), exp_rate[1]);
		check("pitch rate", int'($signed(rates.pitch)), exp_rate[2]);
		check("roll rate", int'($signed(rates.roll)), exp_rate[3]);
		check("yaw error", int'($signed(errors.yaw)), exp_err[0]);
		check("pitch error", int'($signed(errors.pitch)), exp_err[1]);
		check("roll error", int'($signed(errors.roll)), exp_err[2]);
	endtask

	// returns just after the accepting edge
	task automatic drive_start(input attitude_pkg::rx_targets_t t,
		input attitude_pkg::imu_angles_t a);
		@(posedge us_clk);
		start   <= 1'b1;
		targets <= t;
		angles  <= a;
		@(posedge us_clk);
		start   <= 1'b0;
	endtask

	// lat counts edges since the accepting edge
	task automatic wait_done(input int first, output int lat);
		lat = first;
		@(negedge us_clk);
		while (done !== 1'b1 && lat < 20) begin
			@(negedge us_clk);
			lat++;
		end
		if (done !== 1'b1) begin
			timeout_count++;
			$display("Timeout: done did not arrive within 20 cycles at %0t ns", $time);
		end
	endtask

	task automatic run_vector(input attitude_pkg::rx_targets_t t,
		input attitude_pkg::imu_angles_t a);
		int lat;
		predict(t, a);
		drive_start(t, a);
		wait_done(0, lat);
		check("done latency", lat, 4);
		check_outputs();
	endtask

	task automatic write_word(input logic [`CFG_ADDR_W-1:0] addr,
		input attitude_pkg::cfg_word_u w);
		@(posedge us_clk);
		cfg_wr   <= 1'b1;
		cfg_addr <= addr;
		cfg_data <= w;
		@(posedge us_clk);
		cfg_wr   <= 1'b0;
	endtask

	task automatic write_scale(input int idx, input int mult, input int shift);
		attitude_pkg::cfg_word_u w;
		w.scale.mult  = 16'(mult);
		w.scale.shift = 5'(shift);
		write_word(3'(idx), w);
		m_mult[idx]  = mult;
		m_shift[idx] = shift;
	endtask

	task automatic write_limit(input int idx, input int value);
		attitude_pkg::cfg_word_u w;
		w.limit.value = 16'(value);
		w.limit.zero  = 5'd0;
		write_word(3'(4 + idx), w);
		// negative limits are stored as zero
		m_lim[idx] = (value < 0) ? 0 : value;
	endtask

	task automatic random_vector(output attitude_pkg::rx_targets_t t,
		output attitude_pkg::imu_angles_t a);
		t.throttle = 8'(10 + {$random(seed)} % 246);
		t.yaw      = 8'({$random(seed)} % 256);
		t.pitch    = 8'({$random(seed)} % 256);
		t.roll     = 8'({$random(seed)} % 256);
		a.yaw      = 16'({$random(seed)} % 5760);
		a.pitch    = 16'(int'({$random(seed)} % 2881) - 1440);
		a.roll     = 16'(int'({$random(seed)} % 2881) - 1440);
	endtask

	// pitch and roll past the default limits, throttle past 4000
	task automatic run_fixed_vector();
		attitude_pkg::rx_targets_t t;
		attitude_pkg::imu_angles_t a;
		t = '{throttle: 8'd255, yaw: 8'd125, pitch: 8'd0, roll: 8'd255};
		a = '{yaw: 16'sd100, pitch: 16'sd1400, roll: 16'sd1400};
		run_vector(t, a);
	endtask

	task automatic test_defaults();
		attitude_pkg::rx_targets_t t;
		attitude_pkg::imu_angles_t a;
		run_fixed_vector();
		for (int i = 0; i < 6; i++) begin
			random_vector(t, a);
			run_vector(t, a);
		end
	endtask

	task automatic test_heading();
		attitude_pkg::rx_targets_t t;
		attitude_pkg::imu_angles_t a;
		// throttle at idle snaps the heading near 360
		t = '{throttle: 8'd5, yaw: 8'd200, pitch: 8'd125, roll: 8'd125};
		a = '{yaw: 16'sd5700, pitch: 16'sd0, roll: 16'sd0};
		run_vector(t, a);
		t.throttle = 8'd100;
		t.yaw      = 8'd255;
		for (int i = 0; i < 4; i++)
			run_vector(t, a);
		// and back down through zero
		t.yaw = 8'd0;
		a.yaw = 16'sd10;
		for (int i = 0; i < 6; i++)
			run_vector(t, a);
	endtask

	task automatic test_config();
		attitude_pkg::rx_targets_t t;
		attitude_pkg::imu_angles_t a;
		write_scale(2, 3, 1);
		write_limit(2, 2000);
		write_scale(3, 20000, 0);
		write_limit(3, 32767);
		write_scale(0, 20, 0);
		write_limit(0, 30000);
		write_limit(1, -50);
		t = '{throttle: 8'd255, yaw: 8'd125, pitch: 8'd255, roll: 8'd255};
		a = '{yaw: 16'sd10, pitch: -16'sd1000, roll: 16'sd0};
		run_vector(t, a);
		// pitch product far below the 16-bit range, limit wide open
		write_scale(2, -32000, 0);
		write_limit(2, 32767);
		run_vector(t, a);
		write_scale(1, 7, 3);
		write_limit(1, 500);
		t.yaw = 8'd200;
		run_vector(t, a);
	endtask

	task automatic test_timing();
		attitude_pkg::rx_targets_t t1;
		attitude_pkg::rx_targets_t t2;
		attitude_pkg::imu_angles_t a1;
		attitude_pkg::imu_angles_t a2;
		int lat;
		int extra;
		random_vector(t1, a1);
		random_vector(t2, a2);
		// second start while busy, with new inputs that must be ignored
		predict(t1, a1);
		drive_start(t1, a1);
		@(posedge us_clk);
		start   <= 1'b1;
		targets <= t2;
		angles  <= a2;
		@(posedge us_clk);
		start   <= 1'b0;
		@(negedge us_clk);
		check("active while busy", int'(active), 1);
		wait_done(3, lat);
		check("done latency with dropped start", lat, 4);
		check_outputs();
		extra = 0;
		for (int i = 0; i < 8; i++) begin
			@(negedge us_clk);
			if (done === 1'b1)
				extra++;
		end
		check("extra done strobes", extra, 0);
		// back-to-back at 4-cycle spacing
		predict(t1, a1);
		drive_start(t1, a1);
		repeat (3) @(posedge us_clk);
		start   <= 1'b1;
		targets <= t2;
		angles  <= a2;
		@(posedge us_clk);
		start   <= 1'b0;
		@(negedge us_clk);
		check("first back-to-back done", int'(done), 1);
		check_outputs();
		predict(t2, a2);
		wait_done(1, lat);
		check("second back-to-back latency", lat, 4);
		check_outputs();
	endtask

	task automatic test_reset();
		attitude_pkg::rx_targets_t t;
		attitude_pkg::imu_angles_t a;
		random_vector(t, a);
		drive_start(t, a);
		@(posedge us_clk);
		rst_n_tb <= 1'b0;
		@(negedge us_clk);
		check("active in reset", int'(active), 0);
		check("done in reset", int'(done), 0);
		check("rates in reset", int'(rates != '0), 0);
		check("errors in reset", int'(errors != '0), 0);
		@(posedge us_clk);
		rst_n_tb <= 1'b1;
		reset_model();
		run_fixed_vector();
	endtask

	initial begin
		int n;
		seed          = 10003;
		err_count     = 0;
		timeout_count = 0;
		rst_n_tb      = 1'b1;
		cfg_wr        = 1'b0;
		cfg_addr      = '0;
		cfg_data      = '0;
		start         = 1'b0;
		targets       = '0;
		angles        = '0;
		reset_model();
		n = 0;
		while (por_n !== 1'b1 && n < 10) begin
			@(negedge us_clk);
			n++;
		end
		if (por_n !== 1'b1) begin
			timeout_count++;
			$display("Timeout: reset was not released");
		end
		test_defaults();
		test_heading();
		test_config();
		test_timing();
		test_reset();
		$display("errors: %0d, timeouts: %0d", err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verilog
verilog/attitude_pkg.sv
verilog/attitude_cfg_regs.sv
verilog/angle_controller.sv
verilog/attitude_top.sv
testbench/tb_clock.sv
testbench/attitude_chk.sv
testbench/tb_attitude.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_attitude
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
